//--- dv/rs_decoder_tb.sv
/*
  RS(255,239) decoder testbench
  random codewords with recorded error patterns, scoreboard queues
  and immediate assertions on the per-position and end-of-frame reports
*/

`include "rs_config.svh"

module rs_decoder_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import rs_gf_pkg::*;
  import rs_frame_pkg::*;

  logic  iclk;
  logic  ireset;
  logic  iclkena;
  logic  isop;
  logic  ival;
  data_t idat;
  logic  oerr_val;
  pos_t  oerr_pos;
  data_t oerr_mag;
  logic  oframe_done;
  cnt_t  oerr_cnt;
  logic  odecfail;
  tag_t  otag;

  // field tables, exp doubled so log sums need no wrap
  int    exp_tab [0:509];
  int    log_tab [0:255];
  data_t gen     [0:`RS_CHECK];

  // scoreboard, one entry per symbol or per frame
  data_t rx_q   [$];
  data_t mag_q  [$];
  tag_t  tag_q  [$];
  bit    kind_q [$];
  int    nerr_q [$];
  string name_q [$];

  // received word xor reported pattern, arrival order
  data_t fixed [0:`RS_N-1];
  int    pos_cnt;
  int    frames_sent;
  int    frames_done;
  tag_t  next_tag;
  logic  idle_phase;
  int    seed_val;

  rs_decoder_top dut0 (
    .iclk        (iclk),
    .ireset      (ireset),
    .iclkena     (iclkena),
    .isop        (isop),
    .ival        (ival),
    .idat        (idat),
    .oerr_val    (oerr_val),
    .oerr_pos    (oerr_pos),
    .oerr_mag    (oerr_mag),
    .oframe_done (oframe_done),
    .oerr_cnt    (oerr_cnt),
    .odecfail    (odecfail),
    .otag        (otag)
  );

  initial begin
    iclk = 1'b0;
    forever #5 iclk = ~iclk;
  end

  // --------------------------------------------------------------------------
  // reporting and field arithmetic
  // --------------------------------------------------------------------------

  task automatic stop_run();
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_fail(input string msg);
    $display("ERROR: %s", msg);
    stop_run();
  endtask

  task automatic value_fail(input string test, input string what, input int exp, input int act);
    $display("FAILED %s %s expected %0h actual %0h", test, what, exp, act);
    stop_run();
  endtask

  function automatic data_t gmul(data_t a, data_t b);
    if (a == '0 || b == '0) begin
      return '0;
    end
    return data_t'(exp_tab[log_tab[a] + log_tab[b]]);
  endfunction

  task automatic build_tables();
    int x;
    x = 1;
    for (int i = 0; i < 255; i++) begin
      exp_tab[i]       = x;
      exp_tab[i + 255] = x;
      log_tab[x]       = i;
      x = x << 1;
      if (x & 256) begin
        x = x ^ `RS_IRRPOL;
      end
    end
  endtask

  // g(x) = prod (x + alpha^i), coefficient index is the power of x
  task automatic build_generator();
    data_t root;
    foreach (gen[j]) begin
      gen[j] = (j == 0) ? data_t'(1) : '0;
    end
    for (int i = 0; i < `RS_CHECK; i++) begin
      root = data_t'(exp_tab[i + `RS_GENSTART]);
      for (int j = `RS_CHECK; j > 0; j--) begin
        gen[j] = gen[j-1] ^ gmul(gen[j], root);
      end
      gen[0] = gmul(gen[0], root);
    end
  endtask

  // arrival index a carries the coefficient of x^(n-1-a)
  function automatic bit syndromes_zero();
    data_t s;
    for (int i = 0; i < `RS_CHECK; i++) begin
      s = '0;
      for (int a = 0; a < `RS_N; a++) begin
        s ^= gmul(fixed[a], data_t'(exp_tab[((i + `RS_GENSTART) * (`RS_N - 1 - a)) % 255]));
      end
      if (s != '0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // --------------------------------------------------------------------------
  // checking, sampled mid-cycle, only on cycles the DUT advances
  // --------------------------------------------------------------------------

  task automatic check_position();
    data_t exp_mag;
    data_t rx_sym;
    if (mag_q.size() == 0) begin
      report_fail("error strobe with no frame outstanding");
    end
    else begin
      exp_mag = mag_q.pop_front();
      rx_sym  = rx_q.pop_front();
      a_pos : assert (oerr_pos == pos_t'(pos_cnt))
        else value_fail(name_q[0], "position", pos_cnt, oerr_pos);
      if (!kind_q[0]) begin
        a_mag : assert (oerr_mag == exp_mag)
          else value_fail(name_q[0], "magnitude", exp_mag, oerr_mag);
      end
      fixed[pos_cnt] = rx_sym ^ oerr_mag;
      pos_cnt++;
    end
  endtask

  task automatic check_frame_end();
    string name;
    tag_t  tag;
    bit    kind;
    int    nerr;
    if (tag_q.size() == 0) begin
      report_fail("frame done with no frame outstanding");
    end
    else begin
      name = name_q.pop_front();
      tag  = tag_q.pop_front();
      kind = kind_q.pop_front();
      nerr = nerr_q.pop_front();
      a_len : assert (pos_cnt == `RS_N)
        else value_fail(name, "positions reported", `RS_N, pos_cnt);
      a_tag : assert (otag == tag)
        else value_fail(name, "tag", tag, otag);
      if (!kind) begin
        a_cnt : assert (oerr_cnt == cnt_t'(nerr))
          else value_fail(name, "error count", nerr, oerr_cnt);
        a_fail : assert (!odecfail)
          else value_fail(name, "decode failure", 0, odecfail);
      end
      else begin
        a_cnt_max : assert (oerr_cnt <= cnt_t'(`RS_ERRS))
          else value_fail(name, "error count limit", `RS_ERRS, oerr_cnt);
        // a claimed correction has to land on a codeword
        if (!odecfail) begin
          a_synd : assert (syndromes_zero())
            else report_fail("uncorrectable frame decoded to a non-codeword");
        end
      end
      pos_cnt = 0;
      frames_done++;
    end
  endtask

  always @(negedge iclk) begin
    if (idle_phase) begin
      a_idle : assert (!oerr_val && !oframe_done && !odecfail)
        else report_fail("decoder output active before any frame was sent");
    end
    else if (!ireset && iclkena) begin
      // one frame ends while the next shows its first position
      if (oframe_done) begin
        check_frame_end();
      end
      if (oerr_val) begin
        check_position();
      end
    end
  end

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  // retries until the symbol is taken, jitter adds gaps and stalls
  task automatic drive_symbol(input data_t d, input logic sop, input bit jitter);
    logic taken;
    int   tries;
    taken = 1'b0;
    tries = 0;
    while (!taken) begin
      iclkena = !(jitter && $urandom_range(3) == 0);
      ival    = !(jitter && $urandom_range(3) == 0);
      isop    = sop;
      idat    = d;
      taken   = iclkena && ival;
      @(posedge iclk);
      #1;
      tries++;
      if (tries > 100) begin
        report_fail("symbol never accepted");
      end
    end
    iclkena = 1'b1;
    ival    = 1'b0;
    isop    = 1'b0;
  endtask

  task automatic send_frame(input string name, input bit kind, input int nerr,
                            input bit jitter, input bit near_cw);
    data_t msg [0:`RS_N-`RS_CHECK-1];
    data_t cw  [0:`RS_N-1];
    data_t err [0:`RS_N-1];
    data_t rx  [0:`RS_N-1];
    int    p;
    foreach (msg[k]) begin
      msg[k] = data_t'($urandom_range(255));
    end
    // non-systematic codeword m(x) * g(x)
    for (int k = 0; k < `RS_N; k++) begin
      cw[k]  = '0;
      err[k] = '0;
      for (int j = 0; j <= `RS_CHECK; j++) begin
        if (k - j >= 0 && k - j < `RS_N - `RS_CHECK) begin
          cw[k] ^= gmul(msg[k-j], gen[j]);
        end
      end
    end
    if (near_cw) begin
      // low terms of g(x), the word lies closer to c(x) + g(x) than to c(x)
      for (int j = 0; j < nerr; j++) begin
        err[`RS_N - 1 - j] = gen[j];
      end
    end
    else begin
      // distinct positions, nonzero values
      for (int n = 0; n < nerr; n++) begin
        p = $urandom_range(`RS_N - 1);
        while (err[p] != '0) begin
          p = $urandom_range(`RS_N - 1);
        end
        err[p] = data_t'($urandom_range(255, 1));
      end
    end
    for (int a = 0; a < `RS_N; a++) begin
      rx[a] = cw[`RS_N - 1 - a] ^ err[a];
      rx_q.push_back(rx[a]);
      mag_q.push_back(err[a]);
    end
    name_q.push_back(name);
    kind_q.push_back(kind);
    nerr_q.push_back(nerr);
    tag_q.push_back(next_tag);
    next_tag++;
    frames_sent++;
    idle_phase = 1'b0;
    for (int a = 0; a < `RS_N; a++) begin
      drive_symbol(rx[a], a == 0, jitter);
    end
  endtask

  task automatic wait_frames();
    int idle_cnt;
    int last_done;
    idle_cnt  = 0;
    last_done = frames_done;
    while (frames_done < frames_sent) begin
      @(posedge iclk);
      #1;
      if (frames_done != last_done) begin
        last_done = frames_done;
        idle_cnt  = 0;
      end
      else begin
        idle_cnt++;
      end
      if (idle_cnt > 2000) begin
        report_fail("timed out waiting for oframe_done");
      end
    end
  endtask

  initial begin
    seed_val    = $urandom(32'h2b4a_3472);
    ireset      = 1'b1;
    iclkena     = 1'b1;
    isop        = 1'b0;
    ival        = 1'b0;
    idat        = '0;
    idle_phase  = 1'b1;
    pos_cnt     = 0;
    frames_sent = 0;
    frames_done = 0;
    next_tag    = '0;
    build_tables();
    build_generator();
    repeat (3) @(posedge iclk);
    #1;
    ireset = 1'b0;
    // quiet outputs with no traffic
    repeat (20) begin
      @(posedge iclk);
      #1;
    end
    send_frame("clean", 1'b0, 0, 1'b0, 1'b0);
    wait_frames();
    for (int n = 1; n <= `RS_ERRS; n++) begin
      send_frame("correctable", 1'b0, n, 1'b0, 1'b0);
    end
    wait_frames();
    for (int n = `RS_ERRS + 1; n <= `RS_ERRS + 4; n++) begin
      send_frame("uncorrectable", 1'b1, n, 1'b0, 1'b0);
    end
    // decodes to a neighbouring codeword without a failure flag
    send_frame("miscorrection", 1'b1, `RS_ERRS + 1, 1'b0, 1'b1);
    wait_frames();
    // frames overlap with stalls, tag wraps past 15 here
    for (int f = 0; f < 6; f++) begin
      send_frame("overlap", 1'b0, $urandom_range(`RS_ERRS, 1), 1'b1, 1'b0);
    end
    wait_frames();
    if (frames_done == frames_sent && mag_q.size() == 0) begin
      $display("sim passed");
      $finish;
    end
    else begin
      report_fail("scoreboard not empty at end of run");
    end
  end

endmodule

//--- include/rs_config.svh
/*
  RS(255,239) code parameters over GF(2^8)
  shared by the packages and the decoder modules
*/

`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

// symbol width in bits
`define RS_M        8
// codeword length in symbols
`define RS_N        255
// check symbols per codeword
`define RS_CHECK    16
// correctable symbol errors
`define RS_ERRS     8
// field polynomial x^8+x^4+x^3+x^2+1
`define RS_IRRPOL   285
// exponent of the first generator root
`define RS_GENSTART 0
// frame tag width
`define RS_TAG_W    4

`endif

//--- rs_decoder_top.f
+incdir+include
source/rs_gf_pkg.sv
source/rs_frame_pkg.sv
source/rs_symbol_framer.sv
source/rs_syndrome_cell.sv
source/rs_berlekamp_ribm.sv
source/rs_chien_forney.sv
source/rs_decoder_top.sv
dv/rs_decoder_tb.sv

//--- source/rs_berlekamp_ribm.sv
/*
  reformulated inversionless Berlekamp-Massey key equation solver
  check steps after the load, locator and evaluator valid check+1
  cycles after the syndrome strobe
*/

`include "rs_config.svh"

module rs_berlekamp_ribm (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               iclkena,
  input  logic               synd_val,
  input  rs_frame_pkg::tag_t synd_tag,
  input  rs_gf_pkg::data_t   syndrome   [1:`RS_CHECK],
  output logic               loc_val,
  output rs_gf_pkg::data_t   loc_poly   [0:`RS_ERRS],
  output rs_gf_pkg::data_t   omega_poly [0:`RS_ERRS-1],
  output rs_frame_pkg::tag_t loc_tag
);

  import rs_gf_pkg::*;

  localparam int t     = `RS_ERRS;
  localparam int t2    = `RS_CHECK;
  localparam int t3    = t2 + t;
  localparam int cnt_w = $clog2(t2 + 1);

  typedef enum logic {
    st_wait,
    st_step
  } state_t;

  state_t state;

  // delta polynomial, top entry stays zero and feeds the theta shift
  data_t gamma [0:t3+1];
  data_t theta [0:t3];
  data_t sigma;
  // signed step counter k, sign bit is the msb
  logic [`RS_M-1:0] kv;

  logic [cnt_w-1:0] step_cnt;
  logic             step_last;
  logic             done;

  //--------------------------------------------------------------------------
  // FSM and step counter
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state     <= st_wait;
      step_cnt  <= '0;
      step_last <= 1'b0;
      done      <= 1'b0;
    end
    else if (iclkena) begin
      case (state)
        st_wait : state <= synd_val  ? st_step : st_wait;
        st_step : state <= step_last ? st_wait : st_step;
        default : state <= st_wait;
      endcase
      // t2 steps, last one flagged a cycle ahead
      if (state == st_wait) begin
        step_cnt  <= cnt_w'(t2);
        step_last <= 1'b0;
      end
      else begin
        step_cnt  <= step_cnt - 1'b1;
        step_last <= (step_cnt == cnt_w'(2));
      end
      done <= (state == st_step) & step_last;
    end
  end

  //--------------------------------------------------------------------------
  // RiBM datapath
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (state == st_wait) begin
        // gamma only on the strobe so the last result stays visible
        if (synd_val) begin
          loc_tag <= synd_tag;
          for (int i = 0; i < t2; i++) begin
            gamma[i] <= syndrome[i+1];
          end
          for (int i = t2; i <= t3+1; i++) begin
            gamma[i] <= (i == t3) ? data_t'(1) : '0;
          end
        end
        for (int i = 0; i < t2; i++) begin
          theta[i] <= syndrome[i+1];
        end
        for (int i = t2; i <= t3; i++) begin
          theta[i] <= (i == t3) ? data_t'(1) : '0;
        end
        sigma <= data_t'(1);
        kv    <= '0;
      end
      else begin
        // delta(r+1) = (sigma*delta(r) - delta0*theta(r)) / x
        for (int i = 0; i <= t3; i++) begin
          gamma[i] <= gf_mult(sigma, gamma[i+1]) ^ gf_mult(gamma[0], theta[i]);
        end
        // nonzero discrepancy with k >= 0 swaps in the shifted delta
        if ((gamma[0] != '0) && !kv[`RS_M-1]) begin
          for (int i = 0; i <= t3; i++) begin
            theta[i] <= gamma[i+1];
          end
          sigma <= gamma[0];
          kv    <= ~kv;
        end
        else begin
          kv <= kv + 1'b1;
        end
      end
    end
  end

  // lambda sits at delta[t .. 2t], omega-high at delta[0 .. t-1]
  always_comb begin
    for (int i = 0; i <= t; i++) begin
      loc_poly[i] = gamma[t+i];
    end
    for (int i = 0; i < t; i++) begin
      omega_poly[i] = gamma[i];
    end
  end

  assign loc_val = done;

  // framer spacing guarantees an idle solver on each new syndrome set
  a_no_synd_in_step : assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && state == st_step) |-> !synd_val);

endmodule

//--- source/rs_chien_forney.sv
/*
  Chien search with Forney magnitude evaluation
  one position per cycle in arrival order, then an end-of-frame
  report with error count and decode failure
*/

`include "rs_config.svh"

module rs_chien_forney (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               iclkena,
  input  logic               loc_val,
  input  rs_gf_pkg::data_t   loc_poly   [0:`RS_ERRS],
  input  rs_gf_pkg::data_t   omega_poly [0:`RS_ERRS-1],
  input  rs_frame_pkg::tag_t loc_tag,
  output logic               oerr_val,
  output rs_frame_pkg::pos_t oerr_pos,
  output rs_gf_pkg::data_t   oerr_mag,
  output logic               oframe_done,
  output rs_frame_pkg::cnt_t oerr_cnt,
  output logic               odecfail,
  output rs_frame_pkg::tag_t otag
);

  import rs_gf_pkg::*;
  import rs_frame_pkg::*;

  localparam int t = `RS_ERRS;
  // Forney scale X^-(2t+genstart) steps by the same power every position
  localparam data_t corr_step = gf_pow_alpha(`RS_CHECK + `RS_GENSTART);

  data_t lam_reg [0:t];
  data_t omg_reg [0:t-1];
  data_t corr_reg;
  data_t lam_even;
  data_t lam_odd;
  data_t omg_sum;
  logic  is_root;
  logic  running;
  logic  last_pos;
  logic  lam0_zero;
  pos_t  pos;
  cnt_t  root_cnt;
  cnt_t  root_cnt_nxt;
  cnt_t  loc_deg;
  cnt_t  deg_reg;
  // tag of the sweep in progress, reported at its end
  tag_t  sweep_tag;

  //--------------------------------------------------------------------------
  // term registers
  //--------------------------------------------------------------------------

  // position p is tested at x = alpha^(p+1), the inverse of its locator
  for (genvar g = 0; g <= t; g++) begin : g_term
    localparam data_t step = gf_pow_alpha(g);
    always_ff @(posedge iclk) begin
      if (iclkena) begin
        if (loc_val) begin
          lam_reg[g] <= gf_mult(loc_poly[g], step);
        end
        else if (running) begin
          lam_reg[g] <= gf_mult(lam_reg[g], step);
        end
      end
    end
    if (g < t) begin : g_omega
      always_ff @(posedge iclk) begin
        if (iclkena) begin
          if (loc_val) begin
            omg_reg[g] <= gf_mult(omega_poly[g], step);
          end
          else if (running) begin
            omg_reg[g] <= gf_mult(omg_reg[g], step);
          end
        end
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (loc_val) begin
        corr_reg <= corr_step;
      end
      else if (running) begin
        corr_reg <= gf_mult(corr_reg, corr_step);
      end
    end
  end

  //--------------------------------------------------------------------------
  // evaluation
  //--------------------------------------------------------------------------

  always_comb begin
    lam_even = '0;
    lam_odd  = '0;
    omg_sum  = '0;
    for (int i = 0; i <= t; i++) begin
      if (i % 2 == 1) begin
        lam_odd ^= lam_reg[i];
      end
      else begin
        lam_even ^= lam_reg[i];
      end
    end
    for (int i = 0; i < t; i++) begin
      omg_sum ^= omg_reg[i];
    end
  end

  assign is_root = (lam_even ^ lam_odd) == '0;
  // x*lambda'(x) equals the odd terms in characteristic 2
  assign oerr_mag = is_root ? gf_mult(gf_mult(omg_sum, corr_reg), gf_inv(lam_odd)) : '0;

  // locator degree from the highest nonzero coefficient
  always_comb begin
    loc_deg = '0;
    for (int i = 1; i <= t; i++) begin
      if (loc_poly[i] != '0) begin
        loc_deg = cnt_t'(i);
      end
    end
  end

  // saturates at errs+1
  assign root_cnt_nxt = (is_root && root_cnt != cnt_t'(t + 1)) ? root_cnt + 1'b1 : root_cnt;
  assign last_pos     = (pos == pos_t'(`RS_N-1));

  //--------------------------------------------------------------------------
  // position sweep and report
  //--------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      running     <= 1'b0;
      pos         <= '0;
      root_cnt    <= '0;
      deg_reg     <= '0;
      lam0_zero   <= 1'b0;
      sweep_tag   <= '0;
      oframe_done <= 1'b0;
      oerr_cnt    <= '0;
      odecfail    <= 1'b0;
      otag        <= '0;
    end
    else if (iclkena) begin
      oframe_done <= 1'b0;
      if (running) begin
        pos      <= pos + 1'b1;
        root_cnt <= root_cnt_nxt;
        if (last_pos) begin
          running     <= 1'b0;
          oframe_done <= 1'b1;
          oerr_cnt    <= root_cnt_nxt;
          // every root of a valid locator lies inside the codeword
          odecfail    <= lam0_zero | (root_cnt_nxt != deg_reg);
          otag        <= sweep_tag;
        end
      end
      // back-to-back frames load on the last position of the previous sweep
      if (loc_val) begin
        running   <= 1'b1;
        pos       <= '0;
        root_cnt  <= '0;
        deg_reg   <= loc_deg;
        lam0_zero <= (loc_poly[0] == '0);
        sweep_tag <= loc_tag;
      end
    end
  end

  assign oerr_val = running;
  assign oerr_pos = pos;

  // solver latency and frame spacing let a new sweep start no earlier
  // than the last position of the one before
  a_no_loc_in_sweep : assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && loc_val) |-> (!running || last_pos));

endmodule

//--- source/rs_decoder_top.sv
/*
  RS(255,239) streaming decoder
  framer, syndrome cell array, RiBM solver and Chien/Forney search
*/

`include "rs_config.svh"

module rs_decoder_top (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               iclkena,
  input  logic               isop,
  input  logic               ival,
  input  rs_gf_pkg::data_t   idat,
  output logic               oerr_val,
  output rs_frame_pkg::pos_t oerr_pos,
  output rs_gf_pkg::data_t   oerr_mag,
  output logic               oframe_done,
  output rs_frame_pkg::cnt_t oerr_cnt,
  output logic               odecfail,
  output rs_frame_pkg::tag_t otag
);

  import rs_gf_pkg::*;
  import rs_frame_pkg::*;

  // symbol broadcast
  logic  sym_val;
  logic  sym_first;
  data_t sym_dat;

  // syndrome set of the last complete frame
  logic  synd_val;
  tag_t  synd_tag;
  data_t syndrome [1:`RS_CHECK];

  // key equation result
  logic  loc_val;
  data_t loc_poly   [0:`RS_ERRS];
  data_t omega_poly [0:`RS_ERRS-1];
  tag_t  loc_tag;

  rs_symbol_framer framer0 (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .isop      (isop),
    .ival      (ival),
    .idat      (idat),
    .sym_val   (sym_val),
    .sym_first (sym_first),
    .sym_dat   (sym_dat),
    .synd_val  (synd_val),
    .synd_tag  (synd_tag)
  );

  //--------------------------------------------------------------------------
  // one cell per generator root, cell g feeds syndrome[g+1]
  //--------------------------------------------------------------------------

  for (genvar g = 0; g < `RS_CHECK; g++) begin : g_synd
    rs_syndrome_cell #(
      .root_idx (g)
    ) cell0 (
      .iclk      (iclk),
      .iclkena   (iclkena),
      .sym_val   (sym_val),
      .sym_first (sym_first),
      .sym_dat   (sym_dat),
      .syndrome  (syndrome[g+1])
    );
  end

  rs_berlekamp_ribm ribm0 (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .synd_val   (synd_val),
    .synd_tag   (synd_tag),
    .syndrome   (syndrome),
    .loc_val    (loc_val),
    .loc_poly   (loc_poly),
    .omega_poly (omega_poly),
    .loc_tag    (loc_tag)
  );

  rs_chien_forney chien0 (
    .iclk        (iclk),
    .ireset      (ireset),
    .iclkena     (iclkena),
    .loc_val     (loc_val),
    .loc_poly    (loc_poly),
    .omega_poly  (omega_poly),
    .loc_tag     (loc_tag),
    .oerr_val    (oerr_val),
    .oerr_pos    (oerr_pos),
    .oerr_mag    (oerr_mag),
    .oframe_done (oframe_done),
    .oerr_cnt    (oerr_cnt),
    .odecfail    (odecfail),
    .otag        (otag)
  );

endmodule

//--- source/rs_frame_pkg.sv
/*
  frame bookkeeping types
  tags, symbol positions and error counts
*/

`include "rs_config.svh"

package rs_frame_pkg;

  // frame tag, wraps freely
  typedef logic [`RS_TAG_W-1:0] tag_t;

  // symbol position 0 .. n-1
  typedef logic [$clog2(`RS_N)-1:0] pos_t;

  // error count 0 .. errs+1, top value is saturation
  typedef logic [$clog2(`RS_ERRS+2)-1:0] cnt_t;

endpackage

//--- source/rs_gf_pkg.sv
/*
  GF(2^m) element type and field arithmetic
  multiply, constant powers of alpha and inverse
*/

`include "rs_config.svh"

package rs_gf_pkg;

  typedef logic [`RS_M-1:0] data_t;

  // number of nonzero field elements
  localparam int field_order = (2 ** `RS_M) - 1;

  // reduction polynomial aligned to the product width
  localparam logic [2*`RS_M-2:0] irr_poly = `RS_IRRPOL;

  //--------------------------------------------------------------------------
  // carry-less multiply then reduce
  //--------------------------------------------------------------------------

  function automatic data_t gf_mult(data_t a, data_t b);
    logic [2*`RS_M-2:0] prod;
    prod = '0;
    // partial products
    for (int i = 0; i < `RS_M; i++) begin
      if (b[i]) begin
        prod ^= {{(`RS_M-1){1'b0}}, a} << i;
      end
    end
    // fold high bits back, msb first
    for (int i = 2*`RS_M-2; i >= `RS_M; i--) begin
      if (prod[i]) begin
        prod ^= irr_poly << (i - `RS_M);
      end
    end
    return prod[`RS_M-1:0];
  endfunction

  // alpha^e for elaboration-time constants only
  function automatic data_t gf_pow_alpha(int e);
    data_t r;
    r = data_t'(1);
    for (int i = 0; i < (e % field_order); i++) begin
      r = gf_mult(r, data_t'(2));
    end
    return r;
  endfunction

  //--------------------------------------------------------------------------
  // inverse as a^(2^m-2) = a^2 * a^4 * ... * a^(2^(m-1))
  //--------------------------------------------------------------------------

  function automatic data_t gf_inv(data_t a);
    data_t r;
    data_t s;
    r = data_t'(1);
    s = a;
    for (int i = 1; i < `RS_M; i++) begin
      s = gf_mult(s, s);
      r = gf_mult(r, s);
    end
    // zero maps to zero
    return r;
  endfunction

endpackage

//--- source/rs_symbol_framer.sv
/*
  symbol framer
  counts symbols from start of frame, broadcasts them to the syndrome
  cells and issues the syndrome-ready pulse with a frame tag
*/

`include "rs_config.svh"

module rs_symbol_framer (
  input  logic               iclk,
  input  logic               ireset,
  input  logic               iclkena,
  input  logic               isop,
  input  logic               ival,
  input  rs_gf_pkg::data_t   idat,
  output logic               sym_val,
  output logic               sym_first,
  output rs_gf_pkg::data_t   sym_dat,
  output logic               synd_val,
  output rs_frame_pkg::tag_t synd_tag
);

  import rs_frame_pkg::*;

  // symbols taken so far in the current frame, zero when idle
  pos_t cnt;
  tag_t frame_tag;
  logic in_frame;
  logic last_sym;

  // symbols outside a frame are dropped
  assign in_frame  = isop | (cnt != '0);
  assign sym_val   = ival & in_frame;
  assign sym_first = ival & isop;
  assign sym_dat   = idat;
  assign last_sym  = sym_val & (cnt == pos_t'(`RS_N-1));

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cnt       <= '0;
      frame_tag <= '0;
      synd_val  <= 1'b0;
      synd_tag  <= '0;
    end
    else if (iclkena) begin
      synd_val <= last_sym;
      if (last_sym) begin
        cnt       <= '0;
        synd_tag  <= frame_tag;
        frame_tag <= frame_tag + 1'b1;
      end
      else if (sym_val) begin
        // isop restarts the count
        cnt <= isop ? pos_t'(1) : cnt + 1'b1;
      end
    end
  end

  // start of frame only when idle or right after the terminal count
  a_sop_aligned : assert property (@(posedge iclk) disable iff (ireset)
    (iclkena && ival && isop) |-> (cnt == '0));

endmodule

//--- source/rs_syndrome_cell.sv
/*
  syndrome cell
  Horner evaluation of the received word at one generator root
*/

`include "rs_config.svh"

module rs_syndrome_cell #(
  parameter int root_idx = 0
) (
  input  logic             iclk,
  input  logic             iclkena,
  input  logic             sym_val,
  input  logic             sym_first,
  input  rs_gf_pkg::data_t sym_dat,
  output rs_gf_pkg::data_t syndrome
);

  import rs_gf_pkg::*;

  // alpha^(root_idx + genstart)
  localparam data_t root = gf_pow_alpha(root_idx + `RS_GENSTART);

  data_t acc_next;

  // first symbol is the highest power of x
  always_comb begin
    if (sym_first) begin
      // restart from zero, so only the symbol remains
      acc_next = sym_dat;
    end
    else begin
      acc_next = gf_mult(syndrome, root) ^ sym_dat;
    end
  end

  // value holds after the last symbol until the next frame starts
  always_ff @(posedge iclk) begin
    if (iclkena && sym_val) begin
      syndrome <= acc_next;
    end
  end

endmodule
